// ==== common/dbg_trace_pkg.sv ====
// Shared trace widths, label table and snapshot layout. Fields pc, d0, d1 must stay in index order ahead of carry.
`default_nettype none

package dbg_trace_pkg;

    // Register and text geometry.
    localparam int ADDR_W       = 20;                 // Address register width.
    localparam int NIBBLES      = ADDR_W / 4;         // Hex digits per field.
    localparam int NUM_FIELDS   = 3;                  // PC, D0, D1.
    localparam int FIELD_DIGIT0 = 4;                  // Position of first hex digit in a field.
    localparam int FIELD_CHARS  = FIELD_DIGIT0 + NIBBLES + 1; // Label, ": ", digits, space.
    localparam int TAIL_CHARS   = 9;                  // "Carry: c" plus line feed.
    localparam int LINE_CHARS   = NUM_FIELDS * FIELD_CHARS + TAIL_CHARS;

    // Two-letter labels, first character in the upper byte.
    localparam logic [0:NUM_FIELDS-1][15:0] field_label = {"PC", "D0", "D1"};

    // One ASCII character.
    typedef logic [7:0] char_t;

    // Register snapshot taken at instruction completion.
    typedef struct packed {
        logic [ADDR_W-1:0] pc;    // Field 0.
        logic [ADDR_W-1:0] d0;    // Field 1.
        logic [ADDR_W-1:0] d1;    // Field 2.
        logic              carry;
    } dbg_snapshot_t;

endpackage

`default_nettype wire

// ==== common/char_if.sv ====
// One-character four-phase req/ack channel. Data and last must be held while req is high.
`timescale 1ns/100ps
`default_nettype none

interface char_if;

    logic                  req;   // Source has a character.
    logic                  ack;   // Sink has taken it.
    dbg_trace_pkg::char_t  data;  // ASCII payload.
    logic                  last;  // Final character of the current group.

    // Producer side.
    modport source (
        output req, data, last,
        input  ack
    );

    // Consumer side.
    modport sink (
        input  req, data, last,
        output ack
    );

endinterface

`default_nettype wire

// ==== hw/snapshot_capture.sv ====
// Holds one snapshot only; a completion seen while busy is dropped, not queued.
`timescale 1ns/100ps
`default_nettype none

module snapshot_capture (
    input  logic                                i_clk,
    input  logic                                i_reset,
    input  logic                                i_instr_done, // Core finished an instruction.
    input  logic [dbg_trace_pkg::ADDR_W-1:0]    i_pc,
    input  logic [dbg_trace_pkg::ADDR_W-1:0]    i_d0,
    input  logic [dbg_trace_pkg::ADDR_W-1:0]    i_d1,
    input  logic                                i_carry,
    input  logic                                i_line_done,  // Sequencer sent the last char.
    output dbg_trace_pkg::dbg_snapshot_t        o_snapshot,
    output logic                                o_start,      // One cycle, kicks the formatters.
    output logic                                o_busy
);

    logic accept; // Completion taken this cycle.

    assign accept = i_instr_done && !o_busy;

    // Idle/busy state and start pulse.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_busy  <= 1'b0;
            o_start <= 1'b0;
        end else begin
            o_start <= accept; // Single cycle, busy blocks a repeat.
            if (accept) begin
                o_busy <= 1'b1;
            end else if (i_line_done) begin
                o_busy <= 1'b0; // Low in the cycle after line_done.
            end
        end
    end

    // Snapshot register, held for the whole line.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_snapshot.pc    <= i_pc;
            o_snapshot.d0    <= i_d0;
            o_snapshot.d1    <= i_d1;
            o_snapshot.carry <= i_carry;
        end
    end

endmodule

`default_nettype wire

// ==== trace_fmt/field_formatter.sv ====
// Sends one ten-character field per start; a start that arrives mid-field is ignored.
`timescale 1ns/100ps
`default_nettype none

module field_formatter #(
    parameter int FIELD_IDX = 0 // Index into the label table.
) (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_start,
    input  logic [dbg_trace_pkg::ADDR_W-1:0] i_value,
    char_if.source                           o_chars
);

    typedef enum logic [1:0] {
        S_IDLE,  // Waiting for start.
        S_REQ,   // Req high, waiting for ack.
        S_DROP   // Req low, waiting for ack to fall.
    } state_t;

    state_t                                         state;
    logic [$clog2(dbg_trace_pkg::FIELD_CHARS)-1:0]  pos;     // Character position.
    logic [dbg_trace_pkg::ADDR_W-1:0]               value_q; // Shifts left a nibble per digit.
    logic                                           in_digits;
    dbg_trace_pkg::char_t                           char_now;

    // Nibble to upper-case ASCII hex.
    function automatic dbg_trace_pkg::char_t hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib}; // 0x37 is "A" - 10.
    endfunction

    assign in_digits = (pos >= dbg_trace_pkg::FIELD_DIGIT0) &&
                       (pos < dbg_trace_pkg::FIELD_CHARS - 1);

    // Character at the current position.
    always_comb begin
        case (pos)
            0:       char_now = dbg_trace_pkg::field_label[FIELD_IDX][15:8];
            1:       char_now = dbg_trace_pkg::field_label[FIELD_IDX][7:0];
            2:       char_now = ":";
            3:       char_now = " ";
            dbg_trace_pkg::FIELD_CHARS - 1:
                     char_now = " "; // Separator before the next field.
            default: char_now = hex_char(value_q[dbg_trace_pkg::ADDR_W-1 -: 4]); // MSD first.
        endcase
    end

    assign o_chars.req  = (state == S_REQ);
    assign o_chars.data = char_now;
    assign o_chars.last = (pos == dbg_trace_pkg::FIELD_CHARS - 1);

    // Four-phase source.
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= S_IDLE;
            pos   <= '0;
        end else begin
            case (state)
                S_IDLE: if (i_start) begin
                    pos   <= '0;
                    state <= S_REQ; // Req one cycle after start.
                end
                S_REQ: if (o_chars.ack) begin
                    state <= S_DROP;
                end
                S_DROP: if (!o_chars.ack) begin
                    if (o_chars.last) begin
                        state <= S_IDLE; // Field done.
                    end else begin
                        pos   <= pos + 1'b1;
                        state <= S_REQ;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Field value, loaded on start and shifted as digits go out.
    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_start) begin
            value_q <= i_value;
        end else if (state == S_DROP && !o_chars.ack && in_digits) begin
            value_q <= value_q << 4;
        end
    end

endmodule

`default_nettype wire

// ==== trace_fmt/line_sequencer.sv ====
// Strictly one character in flight; a start before line_done is ignored.
`timescale 1ns/100ps
`default_nettype none

module line_sequencer (
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_start,
    input  logic                  i_carry,
    char_if.sink                  i_fields [dbg_trace_pkg::NUM_FIELDS],
    output logic                  o_char_req,
    output dbg_trace_pkg::char_t  o_char_data,
    output logic                  o_char_last,
    input  logic                  i_char_ack,
    output logic                  o_line_done  // One cycle after the line feed's ack falls.
);

    localparam int NF = dbg_trace_pkg::NUM_FIELDS;

    typedef enum logic [2:0] {
        S_IDLE,     // Between lines.
        S_FETCH,    // Take next char from formatter or tail.
        S_EXT_REQ,  // External req high.
        S_EXT_DROP, // External req low, waiting for ack low.
        S_FACK      // Acking the formatter.
    } state_t;

    state_t                                         state;
    logic [$clog2(NF+1)-1:0]                        fptr;       // Field index, NF means tail.
    logic [$clog2(dbg_trace_pkg::TAIL_CHARS)-1:0]   tphase;     // Tail character index.
    dbg_trace_pkg::char_t                           hold_data;  // Char in flight.
    logic                                           field_end;  // Held char ends its field.
    logic                                           in_tail;
    logic                                           tail_last;
    dbg_trace_pkg::char_t                           tail_char;

    // Formatter channels flattened for indexing.
    logic [NF-1:0]         f_req;
    logic [NF-1:0]         f_last;
    logic [NF-1:0]         f_ack;
    dbg_trace_pkg::char_t  f_data [NF];

    for (genvar k = 0; k < NF; k++) begin : g_fld
        assign f_req[k]         = i_fields[k].req;
        assign f_last[k]        = i_fields[k].last;
        assign f_data[k]        = i_fields[k].data;
        assign i_fields[k].ack  = f_ack[k];
    end

    assign in_tail   = (fptr == NF);
    assign tail_last = (tphase == dbg_trace_pkg::TAIL_CHARS - 1);

    // Tail text "Carry: c" and line feed.
    always_comb begin
        case (tphase)
            0:       tail_char = "C";
            1:       tail_char = "a";
            2, 3:    tail_char = "r";
            4:       tail_char = "y";
            5:       tail_char = ":";
            6:       tail_char = " ";
            7:       tail_char = i_carry ? "1" : "0";
            default: tail_char = 8'h0A;
        endcase
    end

    assign o_char_req  = (state == S_EXT_REQ);
    assign o_char_data = hold_data;
    assign o_char_last = in_tail && tail_last; // Line feed only.

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state       <= S_IDLE;
            fptr        <= '0;
            tphase      <= '0;
            f_ack       <= '0;
            o_line_done <= 1'b0;
        end else begin
            o_line_done <= 1'b0;
            case (state)
                S_IDLE: if (i_start) begin
                    state <= S_FETCH;
                end
                S_FETCH: if (in_tail || f_req[fptr]) begin
                    state <= S_EXT_REQ; // Others keep req high and wait.
                end
                S_EXT_REQ: if (i_char_ack) begin
                    state <= S_EXT_DROP;
                end
                S_EXT_DROP: if (!i_char_ack) begin
                    if (!in_tail) begin
                        f_ack[fptr] <= 1'b1; // Release formatter now the char is out.
                        state       <= S_FACK;
                    end else if (tail_last) begin
                        fptr        <= '0;
                        tphase      <= '0;
                        o_line_done <= 1'b1;
                        state       <= S_IDLE;
                    end else begin
                        tphase <= tphase + 1'b1;
                        state  <= S_FETCH;
                    end
                end
                S_FACK: if (!f_req[fptr]) begin
                    f_ack[fptr] <= 1'b0;
                    if (field_end) begin
                        fptr <= fptr + 1'b1; // Next field or tail.
                    end
                    state <= S_FETCH;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Holding register, loaded as a character is taken.
    always_ff @(posedge i_clk) begin
        if (state == S_FETCH) begin
            if (in_tail) begin
                hold_data <= tail_char;
                field_end <= 1'b0;
            end else if (f_req[fptr]) begin
                hold_data <= f_data[fptr];
                field_end <= f_last[fptr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_top.sv ====
// One trace line per accepted completion; i_char_ack must follow the four-phase rule.
`timescale 1ns/100ps
`default_nettype none

module trace_top (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic                             i_instr_done,
    input  logic [dbg_trace_pkg::ADDR_W-1:0] i_pc,
    input  logic [dbg_trace_pkg::ADDR_W-1:0] i_d0,
    input  logic [dbg_trace_pkg::ADDR_W-1:0] i_d1,
    input  logic                             i_carry,
    output logic                             o_busy,      // Line in progress.
    output logic                             o_char_req,
    output dbg_trace_pkg::char_t             o_char_data,
    output logic                             o_char_last, // High on the line feed.
    input  logic                             i_char_ack
);

    localparam int NF = dbg_trace_pkg::NUM_FIELDS;
    localparam int AW = dbg_trace_pkg::ADDR_W;

    dbg_trace_pkg::dbg_snapshot_t snapshot;
    logic                         start;
    logic                         line_done;

    char_if fld_if [NF] (); // One channel per formatter.

    snapshot_capture snapshot_capture_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_instr_done (i_instr_done),
        .i_pc         (i_pc),
        .i_d0         (i_d0),
        .i_d1         (i_d1),
        .i_carry      (i_carry),
        .i_line_done  (line_done),
        .o_snapshot   (snapshot),
        .o_start      (start),
        .o_busy       (o_busy)
    );

    // Field k sits k address widths below the top of the struct, above the carry bit.
    for (genvar k = 0; k < NF; k++) begin : g_fmt
        field_formatter #(.FIELD_IDX(k)) field_formatter_inst (
            .i_clk   (i_clk),
            .i_reset (i_reset),
            .i_start (start),
            .i_value (snapshot[AW*(NF-1-k) + 1 +: AW]),
            .o_chars (fld_if[k])
        );
    end

    line_sequencer line_sequencer_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (start),
        .i_carry     (snapshot.carry),
        .i_fields    (fld_if),
        .o_char_req  (o_char_req),
        .o_char_data (o_char_data),
        .o_char_last (o_char_last),
        .i_char_ack  (i_char_ack),
        .o_line_done (line_done)
    );

endmodule

`default_nettype wire

// ==== verif/trace_top_checker.sv ====
// Handshake assertions on the external character port; bound to every trace_top instance.
`timescale 1ns/100ps
`default_nettype none

module trace_top_checker (
    input logic                 i_clk,
    input logic                 i_reset,
    input logic                 i_char_req,
    input dbg_trace_pkg::char_t i_char_data,
    input logic                 i_char_last,
    input logic                 i_char_ack
);

    int failures = 0; // Failed assertion count.

    // A new request waits for the previous ack to fall.
    req_after_ack_low: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_char_req) |-> !$past(i_char_ack))
        else begin
            $error("o_char_req rose while i_char_ack was still high.");
            failures++;
        end

    // Payload held for as long as req is high.
    payload_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_char_req && $past(i_char_req)) |-> ($stable(i_char_data) && $stable(i_char_last)))
        else begin
            $error("o_char_data or o_char_last changed while o_char_req was high.");
            failures++;
        end

    req_low_after_reset: assert property (@(posedge i_clk)
        i_reset |=> !i_char_req)
        else begin
            $error("o_char_req was high in the cycle after reset.");
            failures++;
        end

endmodule

bind trace_top trace_top_checker trace_top_checker_inst (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_char_req  (o_char_req),
    .i_char_data (o_char_data),
    .i_char_last (o_char_last),
    .i_char_ack  (i_char_ack)
);

`default_nettype wire

// ==== verif/tb_trace_top.sv ====
// Directed tests for trace_top; ack delays come from a fixed seed, and the run stops at a cycle limit.
`timescale 1ns/100ps
`default_nettype none

module tb_trace_top;

    localparam int LINES          = 12; // Full and partial lines over all tests.
    localparam int TIMEOUT_CYCLES = LINES * dbg_trace_pkg::LINE_CHARS * 12 + 200;
    localparam int AW             = dbg_trace_pkg::ADDR_W;

    logic                          i_clk = 1'b0;
    logic                          i_reset;
    logic                          i_instr_done;
    logic [AW-1:0]                 i_pc;
    logic [AW-1:0]                 i_d0;
    logic [AW-1:0]                 i_d1;
    logic                          i_carry;
    logic                          o_busy;
    logic                          o_char_req;
    dbg_trace_pkg::char_t          o_char_data;
    logic                          o_char_last;
    logic                          i_char_ack;
    dbg_trace_pkg::char_t          rx_line [$]; // Characters of the line being received.
    logic                          rx_last [$]; // o_char_last seen with each character.
    int                            errors = 0;
    int                            cycles = 0;

    trace_top trace_top_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_instr_done (i_instr_done),
        .i_pc         (i_pc),
        .i_d0         (i_d0),
        .i_d1         (i_d1),
        .i_carry      (i_carry),
        .o_busy       (o_busy),
        .o_char_req   (o_char_req),
        .o_char_data  (o_char_data),
        .o_char_last  (o_char_last),
        .i_char_ack   (i_char_ack)
    );

    always #4 i_clk = ~i_clk; // 8 ns period.

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: the DUT stopped making progress after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic dbg_trace_pkg::dbg_snapshot_t make_snapshot(
        input logic [AW-1:0] pc, input logic [AW-1:0] d0, input logic [AW-1:0] d1,
        input logic carry);
        dbg_trace_pkg::dbg_snapshot_t s;
        s.pc    = pc;
        s.d0    = d0;
        s.d1    = d1;
        s.carry = carry;
        return s;
    endfunction

    // Text line "PC: hhhhh D0: hhhhh D1: hhhhh Carry: c" and LF, upper-case hex, MSD first.
    function automatic string expected_line(input dbg_trace_pkg::dbg_snapshot_t s);
        string         hex_digits;
        string         labels [3];
        logic [AW-1:0] regs [3];
        string         line;
        hex_digits = "0123456789ABCDEF";
        labels[0]  = "PC";
        labels[1]  = "D0";
        labels[2]  = "D1";
        regs[0]    = s.pc;
        regs[1]    = s.d0;
        regs[2]    = s.d1;
        line       = "";
        for (int f = 0; f < 3; f++) begin
            line = {line, labels[f], ": "};
            for (int n = AW / 4 - 1; n >= 0; n--) begin
                line = $sformatf("%s%c", line, hex_digits[regs[f][4*n +: 4]]);
            end
            line = {line, " "};
        end
        return $sformatf("%sCarry: %0d%c", line, s.carry, 8'h0A);
    endfunction

    task automatic check_char(input string name, input int pos,
                              input dbg_trace_pkg::char_t exp, input dbg_trace_pkg::char_t act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s char %0d: expected 0x%02h, actual 0x%02h", name, pos, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s: expected %b, actual %b", name, what, exp, act);
        end
    endtask

    // Received line against the reference text, last flag on the line feed only.
    task automatic check_snapshot_line(input string name, input dbg_trace_pkg::dbg_snapshot_t s);
        string exp;
        exp = expected_line(s);
        for (int i = 0; i < rx_line.size() && i < exp.len(); i++) begin
            check_char(name, i, exp[i], rx_line[i]);
            check_flag(name, $sformatf("o_char_last at char %0d", i), i == exp.len() - 1,
                       rx_last[i]);
        end
    endtask

    // Four-phase sink. Stops at o_char_last or after max_chars characters.
    task automatic receive_line(input int max_delay, input int max_chars, input bit full_line);
        int   delay;
        logic seen_last;
        rx_line.delete();
        rx_last.delete();
        seen_last = 1'b0;
        while (!seen_last && rx_line.size() < max_chars) begin
            @(negedge i_clk);
            if (o_char_req) begin
                rx_line.push_back(o_char_data);
                rx_last.push_back(o_char_last);
                seen_last = o_char_last;
                delay = (max_delay > 0) ? $urandom_range(max_delay, 0) : 0;
                repeat (delay) @(negedge i_clk);
                i_char_ack = 1'b1;
                do begin
                    @(negedge i_clk);
                end while (o_char_req); // Hold ack until req falls.
                i_char_ack = 1'b0;
            end
        end
        if (full_line && !seen_last) begin
            errors++;
            $display("Line did not end within %0d characters", max_chars);
        end else if (full_line && rx_line.size() != dbg_trace_pkg::LINE_CHARS) begin
            errors++;
            $display("Line ended after %0d characters instead of %0d",
                     rx_line.size(), dbg_trace_pkg::LINE_CHARS);
        end
    endtask

    task automatic issue_completion(input dbg_trace_pkg::dbg_snapshot_t s);
        @(negedge i_clk);
        i_pc         = s.pc;
        i_d0         = s.d0;
        i_d1         = s.d1;
        i_carry      = s.carry;
        i_instr_done = 1'b1;
        @(negedge i_clk);
        i_instr_done = 1'b0;
    endtask

    task automatic wait_idle();
        while (o_busy) @(negedge i_clk);
    endtask

    task automatic trace_one(input string name, input dbg_trace_pkg::dbg_snapshot_t s,
                             input int max_delay);
        issue_completion(s);
        receive_line(max_delay, dbg_trace_pkg::LINE_CHARS + 1, 1'b1);
        check_snapshot_line(name, s);
        wait_idle();
    endtask

    task automatic test_single_line();
        trace_one("single_line", make_snapshot(20'h12345, 20'h6789A, 20'hBCDEF, 1'b1), 0);
    endtask

    task automatic test_edge_values();
        trace_one("edge_zeros", make_snapshot(20'h00000, 20'h00000, 20'h00000, 1'b0), 0);
        trace_one("edge_all_f", make_snapshot(20'hFFFFF, 20'hFFFFF, 20'hFFFFF, 1'b0), 0);
        trace_one("edge_alt", make_snapshot(20'hA5A5A, 20'h5A5A5, 20'h0F0F0, 1'b0), 0);
    endtask

    task automatic test_random_acks();
        for (int i = 0; i < 4; i++) begin
            trace_one($sformatf("random_acks_%0d", i),
                      make_snapshot(AW'($urandom), AW'($urandom), AW'($urandom),
                                    1'($urandom)), 3);
        end
    endtask

    task automatic test_drop_while_busy();
        dbg_trace_pkg::dbg_snapshot_t s1;
        s1 = make_snapshot(20'h0ABCD, 20'h1EF01, 20'h23456, 1'b1);
        issue_completion(s1);
        check_flag("drop_while_busy", "o_busy", 1'b1, o_busy);
        issue_completion(make_snapshot(20'h99999, 20'h88888, 20'h77777, 1'b0)); // Dropped.
        receive_line(1, dbg_trace_pkg::LINE_CHARS + 1, 1'b1);
        check_snapshot_line("drop_while_busy", s1);
        wait_idle();
        trace_one("accept_after_idle", make_snapshot(20'h55555, 20'h66666, 20'hC0DE1, 1'b0), 1);
    endtask

    task automatic test_reset_mid_line();
        issue_completion(make_snapshot(20'h13579, 20'h2468A, 20'hFEDCB, 1'b1));
        receive_line(1, 12, 1'b0); // Part of a line, then reset.
        @(negedge i_clk);
        i_reset = 1'b1;
        @(negedge i_clk);
        check_flag("reset_mid_line", "o_char_req", 1'b0, o_char_req);
        check_flag("reset_mid_line", "o_busy", 1'b0, o_busy);
        repeat (3) @(negedge i_clk);
        i_reset = 1'b0;
        trace_one("after_reset", make_snapshot(20'h31415, 20'h92653, 20'h58979, 1'b0), 2);
    endtask

    initial begin
        void'($urandom(54335));
        i_reset      = 1'b1;
        i_instr_done = 1'b0;
        i_pc         = '0;
        i_d0         = '0;
        i_d1         = '0;
        i_carry      = 1'b0;
        i_char_ack   = 1'b0;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;
        test_single_line();
        test_edge_values();
        test_random_acks();
        test_drop_while_busy();
        test_reset_mid_line();
        errors += trace_top_inst.trace_top_checker_inst.failures; // Handshake assertions.
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dbg_trace.f ====
common/dbg_trace_pkg.sv
common/char_if.sv
hw/snapshot_capture.sv
trace_fmt/field_formatter.sv
trace_fmt/line_sequencer.sv
hw/trace_top.sv
verif/trace_top_checker.sv
verif/tb_trace_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_trace_top
FILELIST  ?= dbg_trace.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
